/* Bender.yml */
package:
  name: cpri_rx_buffer

sources:
  - cpri_rx_pkg.sv
  - cpri_symbol_writer.sv
  - cpri_symbol_store.sv
  - cpri_readout_fsm.sv
  - cpri_chip_counter.sv
  - cpri_tx_stage.sv
  - cpri_rx_buffer.sv
  - target: simulation
    files:
      - tb_cpri_rx_buffer.sv

/* cpri_chip_counter.sv */
// Chip counter: read address and chip word index with chip and symbol end flags
module cpri_chip_counter import cpri_rx_pkg::*; #(
    parameter int SYMBOL_WORDS = 3168,
    parameter int CHIP_WORDS   = 96
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_step,
    output logic [MAX_ADDR_W-1:0] o_rd_addr,
    output logic [CHIP_IDX_W-1:0] o_chip_word,
    output logic                  o_chip_last,
    output logic                  o_symb_last
);

    localparam logic [MAX_ADDR_W-1:0] LAST_ADDR = MAX_ADDR_W'(SYMBOL_WORDS - 1);
    localparam logic [CHIP_IDX_W-1:0] LAST_CHIP = CHIP_IDX_W'(CHIP_WORDS - 1);

    logic [MAX_ADDR_W-1:0] rd_addr;
    logic [CHIP_IDX_W-1:0] chip_word;

    // Both counters step on every issued read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_addr   <= '0;
            chip_word <= '0;
        end else if (i_step) begin
            if (rd_addr == LAST_ADDR) begin
                rd_addr <= '0;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (chip_word == LAST_CHIP) begin
                chip_word <= '0;
            end else begin
                chip_word <= chip_word + 1'b1;
            end
        end
    end

    // Flags describe the word at the current address
    assign o_rd_addr   = rd_addr;
    assign o_chip_word = chip_word;
    assign o_chip_last = (chip_word == LAST_CHIP);
    assign o_symb_last = (rd_addr == LAST_ADDR);

    // Symbol length must be whole chips, so both wraps coincide
    a_whole_chips: assert property (@(posedge i_clk) disable iff (i_reset)
        o_symb_last |-> o_chip_last);

endmodule

/* cpri_readout_fsm.sv */
// Readout FSM: streams full banks in acceptance order and releases them
module cpri_readout_fsm import cpri_rx_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rd_en,
    input  logic [1:0] i_bank_full,
    input  logic       i_space,
    input  logic       i_symb_done,
    output logic       o_rd_en,
    output bank_t      o_rd_bank,
    output logic       o_release
);

    rd_state_e state;
    rd_state_e state_nxt;
    bank_t     next_bank;

    // ----------------------------------------------------------
    // Next-state logic
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Start only on the oldest stored symbol
                if (i_rd_en && i_bank_full[next_bank]) begin
                    state_nxt = STREAM;
                end
            end
            STREAM: begin
                if (o_rd_en && i_symb_done) begin
                    state_nxt = RELEASE;
                end
            end
            RELEASE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= IDLE;
            next_bank <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == RELEASE) begin
                next_bank <= ~next_bank;
            end
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------
    // One read per cycle with room downstream
    assign o_rd_en   = (state == STREAM) && i_space;
    assign o_rd_bank = next_bank;
    assign o_release = (state == RELEASE);

    // Reads only come from a bank holding a complete symbol
    a_rd_full_bank: assert property (@(posedge i_clk) disable iff (i_reset)
        o_rd_en |-> i_bank_full[o_rd_bank]);

endmodule

/* cpri_rx_buffer.sv */
// CPRI uplink symbol buffer top: stores uplink symbols and streams them out as chips
module cpri_rx_buffer import cpri_rx_pkg::*; #(
    parameter int SYMBOL_WORDS = 3168,
    parameter int CHIP_WORDS   = 96
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rx_valid,
    input  cpri_word_t i_rx_data,
    input  logic       i_rd_en,
    input  logic       i_tx_ready,
    output logic       o_tready,
    output logic       o_tx_valid,
    output tx_beat_t   o_tx_beat,
    output agc_t       o_fft_agc
);

    wr_req_t               wr_req;
    logic [1:0]            bank_full;
    agc_t                  bank_agc;
    cpri_word_t            rd_data;
    logic                  rd_en;
    bank_t                 rd_bank;
    logic                  rd_release;
    logic                  space;
    logic [MAX_ADDR_W-1:0] rd_addr;
    logic [CHIP_IDX_W-1:0] chip_word;
    logic                  chip_last;
    logic                  symb_last;

    logic                  push_q;
    logic [CHIP_IDX_W-1:0] chip_word_q;
    logic                  chip_last_q;
    logic                  symb_last_q;
    tx_beat_t              push_beat;

    // ----------------------------------------------------------
    // Write side
    // ----------------------------------------------------------
    cpri_symbol_writer #(
        .SYMBOL_WORDS (SYMBOL_WORDS)
    ) writer_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx_valid  (i_rx_valid),
        .i_rx_data   (i_rx_data),
        .i_bank_free (~bank_full),
        .o_wr_req    (wr_req)
    );

    cpri_symbol_store #(
        .SYMBOL_WORDS (SYMBOL_WORDS)
    ) store_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wr_req    (wr_req),
        .i_rd_en     (rd_en),
        .i_rd_bank   (rd_bank),
        .i_rd_addr   (rd_addr),
        .i_release   (rd_release),
        .o_rd_data   (rd_data),
        .o_bank_full (bank_full),
        .o_bank_agc  (bank_agc),
        .o_tready    (o_tready)
    );

    // ----------------------------------------------------------
    // Read side
    // ----------------------------------------------------------
    cpri_readout_fsm readout_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rd_en     (i_rd_en),
        .i_bank_full (bank_full),
        .i_space     (space),
        .i_symb_done (symb_last),
        .o_rd_en     (rd_en),
        .o_rd_bank   (rd_bank),
        .o_release   (rd_release)
    );

    cpri_chip_counter #(
        .SYMBOL_WORDS (SYMBOL_WORDS),
        .CHIP_WORDS   (CHIP_WORDS)
    ) counter_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_step      (rd_en),
        .o_rd_addr   (rd_addr),
        .o_chip_word (chip_word),
        .o_chip_last (chip_last),
        .o_symb_last (symb_last)
    );

    // Counter flags follow the RAM read by one cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            push_q <= 1'b0;
        end else begin
            push_q <= rd_en;
        end
    end

    always_ff @(posedge i_clk) begin
        chip_word_q <= chip_word;
        chip_last_q <= chip_last;
        symb_last_q <= symb_last;
    end

    assign push_beat = '{data: rd_data, chip_word: chip_word_q,
                         chip_last: chip_last_q, symb_end: symb_last_q};

    cpri_tx_stage tx_stage_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_push     (push_q),
        .i_beat     (push_beat),
        .i_agc      (bank_agc),
        .i_tx_ready (i_tx_ready),
        .o_space    (space),
        .o_tx_valid (o_tx_valid),
        .o_tx_beat  (o_tx_beat),
        .o_fft_agc  (o_fft_agc)
    );

endmodule

/* cpri_rx_pkg.sv */
// CPRI uplink symbol buffer shared types, constants and beat structs
package cpri_rx_pkg;

    // ----------------------------------------------------------
    // Sizing and slot filter constants
    // ----------------------------------------------------------

    // Sized for a full 3168-word symbol
    localparam int MAX_ADDR_W = 12;

    // Wide enough for a 96-word chip
    localparam int CHIP_IDX_W = 7;

    // Uplink slots are those with slot % 5 == 4
    localparam int UPLINK_PERIOD = 5;
    localparam int UPLINK_PHASE  = 4;

    // ----------------------------------------------------------
    // Field types
    // ----------------------------------------------------------
    typedef logic [63:0] cpri_word_t;
    typedef logic [6:0]  slot_idx_t;
    typedef logic [3:0]  symb_idx_t;
    typedef logic [31:0] agc_t;
    typedef logic        bank_t;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        RELEASE
    } rd_state_e;

    // Write port of the symbol store
    typedef struct packed {
        logic                  wr_en;
        bank_t                 bank;
        logic [MAX_ADDR_W-1:0] addr;
        cpri_word_t            data;
    } wr_req_t;

    // One output beat
    typedef struct packed {
        cpri_word_t            data;
        logic [CHIP_IDX_W-1:0] chip_word;
        logic                  chip_last;
        logic                  symb_end;
    } tx_beat_t;

endpackage

/* cpri_symbol_store.sv */
// Symbol store: two-bank symbol RAM with full flags and per-bank AGC words
module cpri_symbol_store import cpri_rx_pkg::*; #(
    parameter int SYMBOL_WORDS = 3168
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  wr_req_t               i_wr_req,
    input  logic                  i_rd_en,
    input  bank_t                 i_rd_bank,
    input  logic [MAX_ADDR_W-1:0] i_rd_addr,
    input  logic                  i_release,
    output cpri_word_t            o_rd_data,
    output logic [1:0]            o_bank_full,
    output agc_t                  o_bank_agc,
    output logic                  o_tready
);

    localparam int DEPTH = 2 * SYMBOL_WORDS;
    localparam int IDX_W = $clog2(DEPTH);

    cpri_word_t mem [DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_first;
    logic             wr_last;
    logic [1:0]       bank_full;
    logic [1:0]       filling;
    agc_t             hdr_agc;
    agc_t             bank_agc [2];

    // Bank 1 sits above bank 0
    assign wr_idx = i_wr_req.bank ? IDX_W'(SYMBOL_WORDS) + IDX_W'(i_wr_req.addr)
                                  : IDX_W'(i_wr_req.addr);
    assign rd_idx = i_rd_bank ? IDX_W'(SYMBOL_WORDS) + IDX_W'(i_rd_addr)
                              : IDX_W'(i_rd_addr);

    assign wr_first = i_wr_req.wr_en && (i_wr_req.addr == '0);
    assign wr_last  = i_wr_req.wr_en && (i_wr_req.addr == MAX_ADDR_W'(SYMBOL_WORDS - 1));

    // ----------------------------------------------------------
    // RAM with one-cycle read latency
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_req.wr_en) begin
            mem[wr_idx] <= i_wr_req.data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[rd_idx];
        end
    end

    // AGC from header word, published with the full flag
    always_ff @(posedge i_clk) begin
        if (wr_first) begin
            hdr_agc <= i_wr_req.data[63:32];
        end
        if (wr_last) begin
            bank_agc[i_wr_req.bank] <= hdr_agc;
        end
    end

    // ----------------------------------------------------------
    // Bank occupancy
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bank_full <= '0;
            filling   <= '0;
        end else begin
            if (i_release) begin
                bank_full[i_rd_bank] <= 1'b0;
            end
            if (wr_first) begin
                filling[i_wr_req.bank] <= 1'b1;
            end
            if (wr_last) begin
                filling[i_wr_req.bank]   <= 1'b0;
                bank_full[i_wr_req.bank] <= 1'b1;
            end
        end
    end

    assign o_bank_full = bank_full;
    assign o_bank_agc  = bank_agc[i_rd_bank];
    // Room while a bank is neither being filled nor holding a symbol
    assign o_tready    = ~&(bank_full | filling);

    a_release_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_release |-> bank_full[i_rd_bank]);

endmodule

/* cpri_symbol_writer.sv */
// Symbol writer: parses headers, keeps uplink slots and writes them into a free bank
module cpri_symbol_writer import cpri_rx_pkg::*; #(
    parameter int SYMBOL_WORDS = 3168
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rx_valid,
    input  cpri_word_t i_rx_data,
    input  logic [1:0] i_bank_free,
    output wr_req_t    o_wr_req
);

    localparam logic [MAX_ADDR_W-1:0] LAST_WORD = MAX_ADDR_W'(SYMBOL_WORDS - 1);

    logic [MAX_ADDR_W-1:0] word_cnt;
    logic                  is_header;
    slot_idx_t             slot_idx;
    logic                  uplink_slot;
    bank_t                 target_bank;
    logic                  hdr_accept;
    logic                  accepting;
    bank_t                 last_bank;

    logic                  wr_en_q;
    bank_t                 wr_bank_q;
    logic [MAX_ADDR_W-1:0] wr_addr_q;
    cpri_word_t            wr_data_q;

    // ----------------------------------------------------------
    // Header detection and acceptance
    // ----------------------------------------------------------
    assign is_header   = i_rx_valid && (word_cnt == '0);
    assign slot_idx    = i_rx_data[18:12];
    assign uplink_slot = (int'(slot_idx) % UPLINK_PERIOD) == UPLINK_PHASE;

    // Banks are claimed in alternating order
    assign target_bank = ~last_bank;
    assign hdr_accept  = is_header && uplink_slot && i_bank_free[target_bank];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            word_cnt  <= '0;
            accepting <= 1'b0;
            // First claim after reset goes to bank 0
            last_bank <= 1'b1;
        end else if (i_rx_valid) begin
            if (word_cnt == LAST_WORD) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (is_header) begin
                accepting <= hdr_accept;
                if (hdr_accept) begin
                    last_bank <= target_bank;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Write request register
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= i_rx_valid && (is_header ? hdr_accept : accepting);
        end
    end

    always_ff @(posedge i_clk) begin
        wr_bank_q <= is_header ? target_bank : last_bank;
        wr_addr_q <= word_cnt;
        wr_data_q <= i_rx_data;
    end

    assign o_wr_req = '{wr_en: wr_en_q, bank: wr_bank_q, addr: wr_addr_q, data: wr_data_q};

    // Header write goes to a bank that was free at the header
    a_write_free_bank: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wr_req.wr_en && (o_wr_req.addr == '0) |->
            |($past(i_bank_free) & (2'b01 << o_wr_req.bank)));

endmodule

/* cpri_tx_stage.sv */
// Output stage: two-entry skid buffer pairing each beat with its AGC word
module cpri_tx_stage import cpri_rx_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_push,
    input  tx_beat_t i_beat,
    input  agc_t     i_agc,
    input  logic     i_tx_ready,
    output logic     o_space,
    output logic     o_tx_valid,
    output tx_beat_t o_tx_beat,
    output agc_t     o_fft_agc
);

    tx_beat_t   beat_q [2];
    agc_t       agc_q [2];
    logic [1:0] count_q;
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic       pop;

    assign pop = o_tx_valid && i_tx_ready;

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            beat_q[wr_ptr_q] <= i_beat;
            agc_q[wr_ptr_q]  <= i_agc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q  <= '0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
        end else begin
            count_q <= count_q + 2'(i_push) - 2'(pop);
            if (i_push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
        end
    end

    // Leave a slot for the read already in flight
    assign o_space    = (count_q + 2'(i_push)) <= 2'd1;
    assign o_tx_valid = (count_q != 2'd0);
    assign o_tx_beat  = beat_q[rd_ptr_q];
    assign o_fft_agc  = agc_q[rd_ptr_q];

    a_stall_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_beat) && $stable(o_fft_agc));

endmodule

/* tb_cpri_rx_buffer.sv */
// Testbench for the CPRI uplink symbol buffer: model, scoreboard and watchdog
module tb_cpri_rx_buffer import cpri_rx_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SYM_W  = 48;
    localparam int CHIP_W = 16;
    // Symbols sent over all tests together
    localparam int TOTAL_SYMBOLS   = 15;
    localparam int WATCHDOG_CYCLES = TOTAL_SYMBOLS * 4 * SYM_W;

    logic       i_clk;
    logic       i_reset;
    logic       i_rx_valid;
    cpri_word_t i_rx_data;
    logic       i_rd_en;
    logic       i_tx_ready;
    logic       o_tready;
    logic       o_tx_valid;
    tx_beat_t   o_tx_beat;
    agc_t       o_fft_agc;

    cpri_word_t   sym_words [SYM_W];
    tx_beat_t     exp_beats [$];
    agc_t         exp_agc [$];
    tx_beat_t     cmp_beat;
    agc_t         cmp_agc;
    tx_beat_t     held_beat;
    agc_t         held_agc;
    logic         stalled;
    logic         ready_random;
    logic [31:0]  rng_data;
    logic [31:0]  rng_ready;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           beats_seen;
    int           occupied;
    int           errs_before;
    int           beats_before;

    cpri_rx_buffer #(
        .SYMBOL_WORDS (SYM_W),
        .CHIP_WORDS   (CHIP_W)
    ) dut_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .i_rd_en    (i_rd_en),
        .i_tx_ready (i_tx_ready),
        .o_tready   (o_tready),
        .o_tx_valid (o_tx_valid),
        .o_tx_beat  (o_tx_beat),
        .o_fft_agc  (o_fft_agc)
    );

    always #4 i_clk = ~i_clk;

    // ----------------------------------------------------------
    // Random numbers and reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_data();
        rng_data = xorshift32(rng_data);
        return rng_data;
    endfunction

    // Expected beats and AGC for the symbol held in sym_words
    function automatic void model_symbol();
        tx_beat_t b;
        for (int i = 0; i < SYM_W; i++) begin
            b.data      = sym_words[i];
            b.chip_word = 7'(i % CHIP_W);
            b.chip_last = (i % CHIP_W) == (CHIP_W - 1);
            b.symb_end  = (i == SYM_W - 1);
            exp_beats.push_back(b);
            exp_agc.push_back(sym_words[0][63:32]);
        end
    endfunction

    // ----------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------
    task automatic send_symbol(input slot_idx_t slot, input symb_idx_t symb, input logic gaps);
        cpri_word_t  hdr;
        logic        accept;
        logic [31:0] r;
        hdr        = {next_data(), next_data()};
        hdr[18:12] = slot;
        hdr[11:8]  = symb;
        sym_words[0] = hdr;
        for (int i = 1; i < SYM_W; i++) begin
            sym_words[i] = {next_data(), next_data()};
        end
        // Uplink slots only, and only with a bank left
        accept = ((int'(slot) % 5) == 4) && (occupied < 2);
        if (accept) begin
            model_symbol();
            occupied++;
        end
        for (int i = 0; i < SYM_W; i++) begin
            r = next_data();
            if (gaps && (r[2:0] == 3'd0)) begin
                @(negedge i_clk);
                i_rx_valid = 1'b0;
            end
            @(negedge i_clk);
            i_rx_valid = 1'b1;
            i_rx_data  = sym_words[i];
        end
        @(negedge i_clk);
        i_rx_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_beats.size() != 0) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    // Ready pattern, random or held high
    always @(negedge i_clk) begin
        if (ready_random) begin
            rng_ready  = xorshift32(rng_ready);
            i_tx_ready = rng_ready[0];
        end else begin
            i_tx_ready = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Scoreboard
    // ----------------------------------------------------------
    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (stalled) begin
                assert (o_tx_valid) else begin
                    $display("o_tx_valid dropped while a beat was stalled");
                    errors++;
                end
                assert (o_tx_beat == held_beat) else begin
                    $display("** Error: o_tx_beat expected 0x%h, got 0x%h", held_beat, o_tx_beat);
                    errors++;
                end
                assert (o_fft_agc == held_agc) else begin
                    $display("** Error: o_fft_agc expected 0x%h, got 0x%h", held_agc, o_fft_agc);
                    errors++;
                end
            end
            if (o_tx_valid && i_tx_ready) begin
                beats_seen++;
                if (exp_beats.size() == 0) begin
                    $display("beat transferred with no expected beat pending");
                    errors++;
                end else begin
                    cmp_beat = exp_beats.pop_front();
                    cmp_agc  = exp_agc.pop_front();
                    assert (o_tx_beat.data == cmp_beat.data) else begin
                        $display("** Error: o_tx_beat.data expected 0x%h, got 0x%h",
                                 cmp_beat.data, o_tx_beat.data);
                        errors++;
                    end
                    assert (o_tx_beat.chip_word == cmp_beat.chip_word) else begin
                        $display("** Error: o_tx_beat.chip_word expected 0x%h, got 0x%h",
                                 cmp_beat.chip_word, o_tx_beat.chip_word);
                        errors++;
                    end
                    assert (o_tx_beat.chip_last == cmp_beat.chip_last) else begin
                        $display("** Error: o_tx_beat.chip_last expected 0x%h, got 0x%h",
                                 cmp_beat.chip_last, o_tx_beat.chip_last);
                        errors++;
                    end
                    assert (o_tx_beat.symb_end == cmp_beat.symb_end) else begin
                        $display("** Error: o_tx_beat.symb_end expected 0x%h, got 0x%h",
                                 cmp_beat.symb_end, o_tx_beat.symb_end);
                        errors++;
                    end
                    assert (o_fft_agc == cmp_agc) else begin
                        $display("** Error: o_fft_agc expected 0x%h, got 0x%h",
                                 cmp_agc, o_fft_agc);
                        errors++;
                    end
                    if (cmp_beat.symb_end) begin
                        occupied--;
                    end
                end
            end
            stalled   = o_tx_valid && !i_tx_ready;
            held_beat = o_tx_beat;
            held_agc  = o_fft_agc;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        i_clk        = 1'b0;
        i_reset      = 1'b1;
        i_rx_valid   = 1'b0;
        i_rx_data    = '0;
        i_rd_en      = 1'b0;
        i_tx_ready   = 1'b1;
        ready_random = 1'b0;
        stalled      = 1'b0;
        rng_data     = 32'h930c;
        rng_ready    = xorshift32(32'h930c);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        beats_seen   = 0;
        occupied     = 0;
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);

        errs_before = errors;
        assert (o_tx_valid == 1'b0) else begin
            $display("** Error: o_tx_valid expected 0x0, got 0x%h", o_tx_valid);
            errors++;
        end
        assert (o_tready == 1'b1) else begin
            $display("** Error: o_tready expected 0x1, got 0x%h", o_tready);
            errors++;
        end
        finish_test("reset_state");

        errs_before = errors;
        i_rd_en = 1'b1;
        send_symbol(7'd4, 4'd0, 1'b0);
        send_symbol(7'd9, 4'd1, 1'b0);
        drain();
        send_symbol(7'd79, 4'd2, 1'b0);
        drain();
        finish_test("uplink_in_order");

        // Non-uplink slots must stay silent
        errs_before  = errors;
        beats_before = beats_seen;
        send_symbol(7'd0, 4'd3, 1'b0);
        send_symbol(7'd3, 4'd4, 1'b0);
        send_symbol(7'd10, 4'd5, 1'b0);
        repeat (2 * SYM_W) @(posedge i_clk);
        @(negedge i_clk);
        assert (beats_seen == beats_before) else begin
            $display("non-uplink symbols produced %0d beats", beats_seen - beats_before);
            errors++;
        end
        // No bank claimed by a dropped symbol
        assert (o_tready == 1'b1) else begin
            $display("** Error: o_tready expected 0x1, got 0x%h", o_tready);
            errors++;
        end
        finish_test("non_uplink_dropped");

        errs_before  = errors;
        ready_random <= 1'b1;
        send_symbol(7'd29, 4'd6, 1'b1);
        send_symbol(7'd54, 4'd7, 1'b1);
        drain();
        send_symbol(7'd7, 4'd8, 1'b1);
        send_symbol(7'd124, 4'd9, 1'b1);
        drain();
        ready_random <= 1'b0;
        finish_test("random_backpressure");

        // Both banks filled with readout held off
        errs_before = errors;
        i_rd_en = 1'b0;
        send_symbol(7'd14, 4'd1, 1'b0);
        send_symbol(7'd19, 4'd2, 1'b0);
        repeat (2) @(negedge i_clk);
        assert (o_tready == 1'b0) else begin
            $display("** Error: o_tready expected 0x0, got 0x%h", o_tready);
            errors++;
        end
        send_symbol(7'd24, 4'd3, 1'b0);
        i_rd_en = 1'b1;
        drain();
        repeat (SYM_W) @(negedge i_clk);
        finish_test("full_banks_drop");

        errs_before = errors;
        send_symbol(7'd34, 4'd10, 1'b0);
        send_symbol(7'd44, 4'd11, 1'b0);
        drain();
        finish_test("agc_and_symbol_end");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
cpri_rx_pkg.sv
cpri_symbol_writer.sv
cpri_symbol_store.sv
cpri_readout_fsm.sv
cpri_chip_counter.sv
cpri_tx_stage.sv
cpri_rx_buffer.sv
tb_cpri_rx_buffer.sv
